// File: hw/tile_settings.svh
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Lookup table size of one logic cell.
`define LUT_BITS 16

// Address width into the lookup table.
`define LUT_ADDR_BITS 4

// Logic cells per tile.
`define CELL_COUNT 2

// Outputs driven by the output router.
`define TILE_OUTPUTS 2

`endif

// File: hw/cell_pkg.sv
`include "tile_settings.svh"

package cell_pkg;

   // LUT combination modes.
   typedef enum logic [1:0] {
      MODE_F4   = 2'd0,
      MODE_F3X2 = 2'd1,
      MODE_BSEL = 2'd2
   } comb_mode_e;

   typedef enum logic [1:0] {
      SET_A   = 2'd0,
      SET_F   = 2'd1,
      SET_OFF = 2'd2
   } set_sel_e;

   typedef enum logic [1:0] {
      RST_D   = 2'd0,
      RST_G   = 2'd1,
      RST_OFF = 2'd2
   } rst_sel_e;

   // Storage bit enable source.
   typedef enum logic [1:0] {
      EN_G   = 2'd0,
      EN_C   = 2'd1,
      EN_EXT = 2'd2
   } en_sel_e;

   typedef enum logic [1:0] {
      X_F = 2'd0,
      X_G = 2'd1,
      X_Q = 2'd2
   } x_sel_e;

   typedef enum logic [1:0] {
      Y_Q = 2'd0,
      Y_G = 2'd1,
      Y_F = 2'd2
   } y_sel_e;

   // Field order sets the bit layout in the chain, lut at the top.
   typedef struct packed {
      logic [`LUT_BITS-1:0] lut;
      comb_mode_e           comb_mode;
      logic [2:0]           f_in_sel;
      logic [2:0]           g_in_sel;
      logic [1:0]           dq_sel;
      set_sel_e             set_sel;
      rst_sel_e             rst_sel;
      en_sel_e              en_sel;
      x_sel_e               x_sel;
      y_sel_e               y_sel;
   } cell_cfg_t;

endpackage

// File: hw/route_pkg.sv
`include "tile_settings.svh"

package route_pkg;

   // Router source, cell index in the upper bit.
   typedef enum logic [1:0] {
      SRC_X0 = 2'd0,
      SRC_Y0 = 2'd1,
      SRC_X1 = 2'd2,
      SRC_Y1 = 2'd3
   } route_src_e;

   // One tile output.
   typedef struct packed {
      route_src_e src_a;
      route_src_e src_b;
      logic [3:0] fn;
      logic       registered;
   } route_out_cfg_t;

   // Output 1 sits in the upper half.
   typedef struct packed {
      route_out_cfg_t [`TILE_OUTPUTS-1:0] out;
   } route_cfg_t;

endpackage

// File: hw/config_chain.sv
`timescale 1ns/1ns

module config_chain #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     KLK,
   input  logic     rst_n,
   input  logic     cfg_in,
   input  logic     cfg_shift,
   input  logic     cfg_load,
   output logic     cfg_out,
   output payload_t payload
);

   localparam int W = $bits(payload_t);

   logic [W-1:0] shift_q;

   // New bits enter at the top and walk toward bit 0.
   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         shift_q <= '0;
      end
      else if (cfg_shift)
      begin
         shift_q <= {cfg_in, shift_q[W-1:1]};
      end
   end

   // Active copy, takes the value held before this edge.
   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         payload <= payload_t'('0);
      end
      else if (cfg_load)
      begin
         payload <= payload_t'(shift_q);
      end
   end

   assign cfg_out = shift_q[0];

endmodule

// File: hw/logic_cell.sv
`timescale 1ns/1ns

`include "tile_settings.svh"

module logic_cell (
   input  logic                KLK,
   input  logic                rst_n,
   input  logic                a,
   input  logic                b,
   input  logic                c,
   input  logic                d,
   input  logic                ext_en,
   input  cell_pkg::cell_cfg_t cfg,
   output logic                x,
   output logic                y
);

   logic                      q;
   logic                      dq1;
   logic                      dq2;
   logic [`LUT_ADDR_BITS-1:0] f_addr;
   logic [`LUT_ADDR_BITS-1:0] g_addr;
   logic                      f;
   logic                      g;
   logic                      set_src;
   logic                      rst_src;
   logic                      en_src;

   // Feedback picks, bit 0 for dq1 and bit 1 for dq2.
   assign dq1 = cfg.dq_sel[0] ? q : d;
   assign dq2 = cfg.dq_sel[1] ? q : d;

   always_comb
   begin
      case (cfg.comb_mode)
         cell_pkg::MODE_F3X2:
         begin
            // Each function sees one half of the table.
            f_addr = {1'b0,
                      cfg.f_in_sel[2] ? b : a,
                      cfg.f_in_sel[1] ? c : b,
                      cfg.f_in_sel[0] ? dq1 : c};
            g_addr = {1'b1,
                      cfg.g_in_sel[2] ? b : a,
                      cfg.g_in_sel[1] ? c : b,
                      cfg.g_in_sel[0] ? dq2 : c};
         end
         cell_pkg::MODE_BSEL:
         begin
            f_addr = b ? {1'b1, a, c, dq2} : {1'b0, a, c, dq1};
            g_addr = f_addr;
         end
         default:
         begin
            f_addr = {a, b, c, dq1};
            g_addr = f_addr;
         end
      endcase
   end

   assign f = cfg.lut[f_addr];
   assign g = cfg.lut[g_addr];

   always_comb
   begin
      case (cfg.set_sel)
         cell_pkg::SET_A: set_src = a;
         cell_pkg::SET_F: set_src = f;
         default:         set_src = 1'b0;
      endcase
   end

   always_comb
   begin
      case (cfg.rst_sel)
         cell_pkg::RST_D: rst_src = d;
         cell_pkg::RST_G: rst_src = g;
         default:         rst_src = 1'b0;
      endcase
   end

   always_comb
   begin
      case (cfg.en_sel)
         cell_pkg::EN_G: en_src = g;
         cell_pkg::EN_C: en_src = c;
         default:        en_src = ext_en;
      endcase
   end

   // Storage bit. Reset wins over set, set over F.
   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         q <= 1'b0;
      end
      else if (en_src)
      begin
         if (rst_src)
         begin
            q <= 1'b0;
         end
         else if (set_src)
         begin
            q <= 1'b1;
         end
         else
         begin
            q <= f;
         end
      end
   end

   always_comb
   begin
      case (cfg.x_sel)
         cell_pkg::X_F: x = f;
         cell_pkg::X_G: x = g;
         default:       x = q;
      endcase
   end

   always_comb
   begin
      case (cfg.y_sel)
         cell_pkg::Y_Q: y = q;
         cell_pkg::Y_G: y = g;
         default:       y = f;
      endcase
   end

endmodule

// File: hw/output_router.sv
`timescale 1ns/1ns

`include "tile_settings.svh"

module output_router (
   input  logic                     KLK,
   input  logic                     rst_n,
   input  logic [`CELL_COUNT-1:0]   cell_x,
   input  logic [`CELL_COUNT-1:0]   cell_y,
   input  route_pkg::route_cfg_t    cfg,
   output logic [`TILE_OUTPUTS-1:0] tile_out
);

   logic [`TILE_OUTPUTS-1:0] comb_out;
   logic [`TILE_OUTPUTS-1:0] reg_out;

   function automatic logic pick_src(
      input route_pkg::route_src_e   src,
      input logic [`CELL_COUNT-1:0] xs,
      input logic [`CELL_COUNT-1:0] ys
   );
      case (src)
         route_pkg::SRC_X0: pick_src = xs[0];
         route_pkg::SRC_Y0: pick_src = ys[0];
         route_pkg::SRC_X1: pick_src = xs[1];
         default:           pick_src = ys[1];
      endcase
   endfunction

   // The source pair addresses the table, src_a high.
   always_comb
   begin
      for (int i = 0; i < `TILE_OUTPUTS; i++)
      begin
         comb_out[i] = cfg.out[i].fn[{pick_src(cfg.out[i].src_a, cell_x, cell_y),
                                      pick_src(cfg.out[i].src_b, cell_x, cell_y)}];
      end
   end

   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         reg_out <= '0;
      end
      else
      begin
         reg_out <= comb_out;
      end
   end

   always_comb
   begin
      for (int i = 0; i < `TILE_OUTPUTS; i++)
      begin
         tile_out[i] = cfg.out[i].registered ? reg_out[i] : comb_out[i];
      end
   end

endmodule

// File: hw/lca_tile.sv
`timescale 1ns/1ns

`include "tile_settings.svh"

module lca_tile (
   input  logic                     KLK,
   input  logic                     rst_n,
   input  logic                     cfg_data,
   input  logic                     cfg_shift,
   input  logic                     cfg_load,
   input  logic                     ext_en,
   input  logic [`CELL_COUNT-1:0]   cell_a,
   input  logic [`CELL_COUNT-1:0]   cell_b,
   input  logic [`CELL_COUNT-1:0]   cell_c,
   input  logic [`CELL_COUNT-1:0]   cell_d,
   output logic [`TILE_OUTPUTS-1:0] tile_out,
   output logic [`CELL_COUNT-1:0]   cell_x,
   output logic [`CELL_COUNT-1:0]   cell_y,
   output logic                     cfg_out
);

   logic                  chain_c0;
   logic                  chain_c1;
   cell_pkg::cell_cfg_t   cell0_cfg;
   cell_pkg::cell_cfg_t   cell1_cfg;
   route_pkg::route_cfg_t route_cfg;

   // Chain order is cell 0, cell 1, router.
   config_chain #(.payload_t(cell_pkg::cell_cfg_t)) u_cfg_cell0 (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .cfg_in    (cfg_data),
      .cfg_shift (cfg_shift),
      .cfg_load  (cfg_load),
      .cfg_out   (chain_c0),
      .payload   (cell0_cfg)
   );

   config_chain #(.payload_t(cell_pkg::cell_cfg_t)) u_cfg_cell1 (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .cfg_in    (chain_c0),
      .cfg_shift (cfg_shift),
      .cfg_load  (cfg_load),
      .cfg_out   (chain_c1),
      .payload   (cell1_cfg)
   );

   config_chain #(.payload_t(route_pkg::route_cfg_t)) u_cfg_route (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .cfg_in    (chain_c1),
      .cfg_shift (cfg_shift),
      .cfg_load  (cfg_load),
      .cfg_out   (cfg_out),
      .payload   (route_cfg)
   );

   logic_cell u_cell0 (
      .KLK    (KLK),
      .rst_n  (rst_n),
      .a      (cell_a[0]),
      .b      (cell_b[0]),
      .c      (cell_c[0]),
      .d      (cell_d[0]),
      .ext_en (ext_en),
      .cfg    (cell0_cfg),
      .x      (cell_x[0]),
      .y      (cell_y[0])
   );

   logic_cell u_cell1 (
      .KLK    (KLK),
      .rst_n  (rst_n),
      .a      (cell_a[1]),
      .b      (cell_b[1]),
      .c      (cell_c[1]),
      .d      (cell_d[1]),
      .ext_en (ext_en),
      .cfg    (cell1_cfg),
      .x      (cell_x[1]),
      .y      (cell_y[1])
   );

   output_router u_router (
      .KLK      (KLK),
      .rst_n    (rst_n),
      .cell_x   (cell_x),
      .cell_y   (cell_y),
      .cfg      (route_cfg),
      .tile_out (tile_out)
   );

endmodule

// File: bench/lca_tile_assertions.sv
`timescale 1ns/1ns

`include "tile_settings.svh"

module lca_tile_assertions (
   input logic                     KLK,
   input logic                     rst_n,
   input logic                     cfg_shift,
   input logic                     cfg_out,
   input logic [`TILE_OUTPUTS-1:0] tile_out,
   input logic [`CELL_COUNT-1:0]   cell_x,
   input logic [`CELL_COUNT-1:0]   cell_y,
   input route_pkg::route_cfg_t    route_cfg
);

   // A reset edge clears every output.
   assert property (@(posedge KLK)
      !rst_n |=> (tile_out == '0 && cell_x == '0 && cell_y == '0 && !cfg_out))
      else $error("tile outputs not zero one cycle after reset");

   assert property (@(posedge KLK)
      (rst_n && $past(rst_n) && !$stable(cfg_out)) |-> $past(cfg_shift))
      else $error("cfg_out moved without a shift strobe");

   // A registered output lags its sources by one edge.
   for (genvar i = 0; i < `TILE_OUTPUTS; i++)
   begin : g_reg_out
      assert property (@(posedge KLK)
         (rst_n && $past(rst_n) && $past(rst_n, 2) && route_cfg.out[i].registered
          && $stable(route_cfg) && $past(route_cfg) == $past(route_cfg, 2)
          && $past({cell_x, cell_y}) == $past({cell_x, cell_y}, 2))
         |-> $stable(tile_out[i]))
         else $error("registered tile output moved while its sources were stable");
   end

endmodule

bind lca_tile lca_tile_assertions u_lca_tile_assertions (
   .KLK       (KLK),
   .rst_n     (rst_n),
   .cfg_shift (cfg_shift),
   .cfg_out   (cfg_out),
   .tile_out  (tile_out),
   .cell_x    (cell_x),
   .cell_y    (cell_y),
   .route_cfg (route_cfg)
);

// File: bench/lca_tile_tb.sv
`timescale 1ns/1ns

`include "tile_settings.svh"

module lca_tile_tb;

   localparam int CELL_BITS  = $bits(cell_pkg::cell_cfg_t);
   localparam int ROUTE_BITS = $bits(route_pkg::route_cfg_t);
   localparam int CHAIN_BITS = 2 * CELL_BITS + ROUTE_BITS;

   logic                     KLK;
   logic                     rst_n;
   logic                     cfg_data;
   logic                     cfg_shift;
   logic                     cfg_load;
   logic                     ext_en;
   logic [`CELL_COUNT-1:0]   cell_a;
   logic [`CELL_COUNT-1:0]   cell_b;
   logic [`CELL_COUNT-1:0]   cell_c;
   logic [`CELL_COUNT-1:0]   cell_d;
   logic [`TILE_OUTPUTS-1:0] tile_out;
   logic [`CELL_COUNT-1:0]   cell_x;
   logic [`CELL_COUNT-1:0]   cell_y;
   logic                     cfg_out;
   logic [`CELL_COUNT-1:0]   q_exp;
   int                       errors;
   int                       checks;

   lca_tile u_lca_tile (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .cfg_data  (cfg_data),
      .cfg_shift (cfg_shift),
      .cfg_load  (cfg_load),
      .ext_en    (ext_en),
      .cell_a    (cell_a),
      .cell_b    (cell_b),
      .cell_c    (cell_c),
      .cell_d    (cell_d),
      .tile_out  (tile_out),
      .cell_x    (cell_x),
      .cell_y    (cell_y),
      .cfg_out   (cfg_out)
   );

   always #5 KLK = ~KLK;

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_cfg(input string name, input cell_pkg::cell_cfg_t exp,
                            input cell_pkg::cell_cfg_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   // Position k of a three-input function takes its own input or the next one down.
   function automatic logic [2:0] steer(input logic [2:0] sel, input logic a, b, c, dq);
      logic [3:0] ins;
      ins = {a, b, c, dq};
      for (int k = 0; k < 3; k++)
      begin
         steer[k] = sel[k] ? ins[k] : ins[k + 1];
      end
   endfunction

   // Returns {F, G}.
   function automatic logic [1:0] cell_fg(input cell_pkg::cell_cfg_t cfg,
                                          input logic a, b, c, d, q);
      logic       dq1;
      logic       dq2;
      logic [3:0] fa;
      logic [3:0] ga;
      dq1 = cfg.dq_sel[0] ? q : d;
      dq2 = cfg.dq_sel[1] ? q : d;
      fa = {a, b, c, dq1};
      ga = fa;
      if (cfg.comb_mode == cell_pkg::MODE_F3X2)
      begin
         fa = {1'b0, steer(cfg.f_in_sel, a, b, c, dq1)};
         ga = {1'b1, steer(cfg.g_in_sel, a, b, c, dq2)};
      end
      else if (cfg.comb_mode == cell_pkg::MODE_BSEL)
      begin
         fa = {b, a, c, b ? dq2 : dq1};
         ga = fa;
      end
      cell_fg = {cfg.lut[fa], cfg.lut[ga]};
   endfunction

   function automatic logic q_next(input cell_pkg::cell_cfg_t cfg, input logic q,
                                   input logic a, b, c, d, en_pin);
      logic [1:0] fg;
      logic       en;
      logic       clr;
      logic       set;
      fg = cell_fg(cfg, a, b, c, d, q);
      en = (cfg.en_sel == cell_pkg::EN_G) ? fg[0] : (cfg.en_sel == cell_pkg::EN_C) ? c : en_pin;
      clr = (cfg.rst_sel == cell_pkg::RST_D) ? d : (cfg.rst_sel == cell_pkg::RST_G) & fg[0];
      set = (cfg.set_sel == cell_pkg::SET_A) ? a : (cfg.set_sel == cell_pkg::SET_F) & fg[1];
      q_next = !en ? q : clr ? 1'b0 : set ? 1'b1 : fg[1];
   endfunction

   // Sources are numbered x0, y0, x1, y1.
   function automatic logic route_ref(input route_pkg::route_out_cfg_t oc,
                                      input logic [`CELL_COUNT-1:0] xs, ys);
      logic [3:0] srcs;
      srcs = {ys[1], xs[1], ys[0], xs[0]};
      route_ref = oc.fn[{srcs[oc.src_a], srcs[oc.src_b]}];
   endfunction

   function automatic cell_pkg::cell_cfg_t base_cfg(input logic [`LUT_BITS-1:0] lut,
                                                   input cell_pkg::comb_mode_e mode);
      base_cfg = '0;
      base_cfg.lut = lut;
      base_cfg.comb_mode = mode;
      base_cfg.set_sel = cell_pkg::SET_OFF;
      base_cfg.rst_sel = cell_pkg::RST_OFF;
      base_cfg.en_sel = cell_pkg::EN_G;
      base_cfg.x_sel = cell_pkg::X_F;
      base_cfg.y_sel = cell_pkg::Y_G;
   endfunction

   // Router bits travel farthest, so the chain takes them first, LSB first.
   task automatic load_config(input cell_pkg::cell_cfg_t c0, c1, input route_pkg::route_cfg_t rt);
      logic [CHAIN_BITS-1:0] bits;
      bits = {c0, c1, rt};
      for (int i = 0; i < CHAIN_BITS; i++)
      begin
         @(posedge KLK);
         cfg_data <= bits[i];
         cfg_shift <= 1'b1;
      end
      @(posedge KLK);
      cfg_data <= 1'b0;
      cfg_shift <= 1'b0;
      cfg_load <= 1'b1;
      @(posedge KLK);
      cfg_load <= 1'b0;
   endtask

   task automatic apply_inputs(input logic [`CELL_COUNT-1:0] a, b, c, d, input logic en);
      @(posedge KLK);
      cell_a <= a;
      cell_b <= b;
      cell_c <= c;
      cell_d <= d;
      ext_en <= en;
      @(negedge KLK);
   endtask

   task automatic wait_idle(input int limit);
      for (int n = 0; n < limit; n++)
      begin
         @(negedge KLK);
         if (tile_out === '0 && cell_x === '0 && cell_y === '0 && cfg_out === 1'b0)
         begin
            break;
         end
      end
      if (tile_out !== '0 || cell_x !== '0 || cell_y !== '0 || cfg_out !== 1'b0)
      begin
         errors++;
         $display("Timeout: tile outputs did not settle to zero after reset");
      end
   endtask

   task automatic chain_passthrough();
      logic [CHAIN_BITS-1:0] sent;
      logic [CHAIN_BITS-1:0] got;
      logic [31:0]           r0;
      logic [31:0]           r1;
      logic [31:0]           r2;
      wait_idle(4);
      for (int i = 0; i < `TILE_OUTPUTS; i++)
      begin
         check_bit("reset_tile_out", 1'b0, tile_out[i]);
      end
      for (int i = 0; i < `CELL_COUNT; i++)
      begin
         check_bit("reset_cell_x", 1'b0, cell_x[i]);
         check_bit("reset_cell_y", 1'b0, cell_y[i]);
      end
      check_bit("reset_cfg_out", 1'b0, cfg_out);
      r0 = $urandom();
      r1 = $urandom();
      r2 = $urandom();
      sent = {r2[25:0], r1, r0};
      got = '0;
      for (int k = 0; k < 2 * CHAIN_BITS; k++)
      begin
         @(posedge KLK);
         cfg_data <= (k < CHAIN_BITS) ? sent[k] : 1'b0;
         cfg_shift <= 1'b1;
         @(negedge KLK);
         // k shifts have happened by now.
         if (k >= CHAIN_BITS)
         begin
            got[k - CHAIN_BITS] = cfg_out;
            check_bit("chain_passthrough", sent[k - CHAIN_BITS], cfg_out);
         end
      end
      @(posedge KLK);
      cfg_shift <= 1'b0;
      check_cfg("chain_cell0", sent[CHAIN_BITS-1 -: CELL_BITS], got[CHAIN_BITS-1 -: CELL_BITS]);
      check_cfg("chain_cell1", sent[ROUTE_BITS +: CELL_BITS], got[ROUTE_BITS +: CELL_BITS]);
   endtask

   task automatic four_input_mode();
      cell_pkg::cell_cfg_t cfg [`CELL_COUNT];
      logic [31:0]         r;
      for (int t = 0; t < 4; t++)
      begin
         for (int n = 0; n < `CELL_COUNT; n++)
         begin
            r = $urandom();
            cfg[n] = base_cfg(r[15:0], cell_pkg::MODE_F4);
         end
         load_config(cfg[0], cfg[1], '0);
         for (int v = 0; v < 16; v++)
         begin
            r = $urandom();
            apply_inputs(r[1:0], r[3:2], r[5:4], r[7:6], 1'b0);
            for (int n = 0; n < `CELL_COUNT; n++)
            begin
               check_bit("four_input_x", cfg[n].lut[{cell_a[n], cell_b[n], cell_c[n], cell_d[n]}],
                         cell_x[n]);
            end
         end
      end
   endtask

   task automatic split_modes();
      cell_pkg::cell_cfg_t cfg [`CELL_COUNT];
      cell_pkg::comb_mode_e mode;
      logic [31:0]         r;
      logic [1:0]          fg;
      for (int t = 0; t < 6; t++)
      begin
         mode = cell_pkg::MODE_F3X2;
         if (t % 2 == 1)
         begin
            mode = cell_pkg::MODE_BSEL;
         end
         for (int n = 0; n < `CELL_COUNT; n++)
         begin
            r = $urandom();
            cfg[n] = base_cfg(r[15:0], mode);
            cfg[n].f_in_sel = r[18:16];
            cfg[n].g_in_sel = r[21:19];
         end
         load_config(cfg[0], cfg[1], '0);
         for (int v = 0; v < 12; v++)
         begin
            r = $urandom();
            apply_inputs(r[1:0], r[3:2], r[5:4], r[7:6], 1'b0);
            for (int n = 0; n < `CELL_COUNT; n++)
            begin
               fg = cell_fg(cfg[n], cell_a[n], cell_b[n], cell_c[n], cell_d[n], 1'b0);
               check_bit((t % 2 == 1) ? "bsel_f" : "f3x2_f", fg[1], cell_x[n]);
               check_bit((t % 2 == 1) ? "bsel_g" : "f3x2_g", fg[0], cell_y[n]);
            end
         end
      end
   endtask

   // Inputs stay put for a second edge, which leaves q where it is.
   task automatic storage_step(input string name, input cell_pkg::cell_cfg_t cfg,
                               input logic [`CELL_COUNT-1:0] a, b, c, d, input logic en);
      apply_inputs(a, b, c, d, en);
      for (int n = 0; n < `CELL_COUNT; n++)
      begin
         q_exp[n] = q_next(cfg, q_exp[n], a[n], b[n], c[n], d[n], en);
      end
      @(posedge KLK);
      @(negedge KLK);
      for (int n = 0; n < `CELL_COUNT; n++)
      begin
         check_bit(name, q_exp[n], cell_y[n]);
      end
   endtask

   task automatic storage_bit();
      cell_pkg::cell_cfg_t cfg;
      logic [31:0]         r;
      r = $urandom();
      cfg = base_cfg(r[15:0], cell_pkg::MODE_F4);
      cfg.set_sel = cell_pkg::SET_A;
      cfg.rst_sel = cell_pkg::RST_D;
      cfg.en_sel = cell_pkg::EN_EXT;
      cfg.y_sel = cell_pkg::Y_Q;
      load_config(cfg, cfg, '0);
      storage_step("store_reset", cfg, 2'b00, 2'b00, 2'b00, 2'b11, 1'b1);
      storage_step("store_set", cfg, 2'b11, 2'b00, 2'b00, 2'b00, 1'b1);
      storage_step("store_hold", cfg, 2'b00, 2'b00, 2'b00, 2'b11, 1'b0);
      storage_step("store_reset_over_set", cfg, 2'b11, 2'b00, 2'b00, 2'b11, 1'b1);
      storage_step("store_load_f", cfg, 2'b00, r[17:16], r[19:18], 2'b00, 1'b1);
      for (int v = 0; v < 16; v++)
      begin
         r = $urandom();
         storage_step("store_random", cfg, r[1:0], r[3:2], r[5:4], r[7:6], r[8]);
      end
      cfg.en_sel = cell_pkg::EN_C;
      load_config(cfg, cfg, '0);
      storage_step("store_c_reset", cfg, 2'b00, 2'b00, 2'b11, 2'b11, 1'b0);
      for (int v = 0; v < 12; v++)
      begin
         r = $urandom();
         storage_step("store_c_random", cfg, r[1:0], r[3:2], r[5:4], r[7:6], r[8]);
      end
   endtask

   task automatic router_outputs();
      cell_pkg::cell_cfg_t      cfg;
      route_pkg::route_cfg_t    rt;
      logic [31:0]              r;
      logic [1:0]               fg;
      logic [`CELL_COUNT-1:0]   xs;
      logic [`CELL_COUNT-1:0]   ys;
      logic [`TILE_OUTPUTS-1:0] exp_now;
      logic [`TILE_OUTPUTS-1:0] exp_prev;
      logic                     have_prev;
      // F follows a and G follows b.
      cfg = base_cfg(16'hCCF0, cell_pkg::MODE_F3X2);
      for (int t = 0; t < 4; t++)
      begin
         r = $urandom();
         rt = route_pkg::route_cfg_t'(r[17:0]);
         rt.out[0].registered = (t % 2 == 1);
         rt.out[1].registered = (t % 2 == 0);
         load_config(cfg, cfg, rt);
         have_prev = 1'b0;
         exp_prev = '0;
         for (int v = 0; v < 16; v++)
         begin
            r = $urandom();
            apply_inputs(r[1:0], r[3:2], r[5:4], r[7:6], 1'b0);
            for (int n = 0; n < `CELL_COUNT; n++)
            begin
               fg = cell_fg(cfg, cell_a[n], cell_b[n], cell_c[n], cell_d[n], 1'b0);
               xs[n] = fg[1];
               ys[n] = fg[0];
            end
            for (int i = 0; i < `TILE_OUTPUTS; i++)
            begin
               exp_now[i] = route_ref(rt.out[i], xs, ys);
               if (!rt.out[i].registered)
               begin
                  check_bit("route_comb", exp_now[i], tile_out[i]);
               end
               else if (have_prev)
               begin
                  check_bit("route_registered", exp_prev[i], tile_out[i]);
               end
            end
            exp_prev = exp_now;
            have_prev = 1'b1;
         end
      end
   endtask

   initial
   begin
      void'($urandom(32'h7920_a026));
      errors = 0;
      checks = 0;
      q_exp = '0;
      KLK = 1'b0;
      rst_n = 1'b0;
      cfg_data = 1'b0;
      cfg_shift = 1'b0;
      cfg_load = 1'b0;
      ext_en = 1'b0;
      cell_a = '0;
      cell_b = '0;
      cell_c = '0;
      cell_d = '0;
      repeat (16) @(posedge KLK);
      rst_n <= 1'b1;
      chain_passthrough();
      four_input_mode();
      split_modes();
      storage_bit();
      router_outputs();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+hw
hw/cell_pkg.sv
hw/route_pkg.sv
hw/config_chain.sv
hw/logic_cell.sv
hw/output_router.sv
hw/lca_tile.sv
bench/lca_tile_assertions.sv
bench/lca_tile_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lca_tile_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
